/* design/friscv_pkg.sv */
package friscv_pkg;

    localparam int XLEN   = 32;
    localparam int NREGS  = 32;
    localparam int APB_AW = 8;

    localparam logic [XLEN-1:0] RESET_PC = '0;

    // APB register map, byte addresses
    localparam logic [APB_AW-1:0] ADDR_INSTR   = 8'h00;
    localparam logic [APB_AW-1:0] ADDR_PC      = 8'h04;
    localparam logic [APB_AW-1:0] ADDR_RETIRED = 8'h08;
    localparam logic [APB_AW-1:0] ADDR_ILLEGAL = 8'h0C;
    localparam logic [APB_AW-1:0] ADDR_REGBASE = 8'h80;

    typedef enum logic [6:0] {
        OPC_LUI    = 7'b0110111,
        OPC_AUIPC  = 7'b0010111,
        OPC_JAL    = 7'b1101111,
        OPC_JALR   = 7'b1100111,
        OPC_BRANCH = 7'b1100011,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_OPIMM  = 7'b0010011,
        OPC_OP     = 7'b0110011,
        OPC_FENCE  = 7'b0001111,
        OPC_SYSTEM = 7'b1110011
    } opcode_e;

    typedef enum logic [1:0] {
        CLS_JUMP    = 2'd0,
        CLS_BRANCH  = 2'd1,
        CLS_PROCESS = 2'd2,
        CLS_SYSTEM  = 2'd3
    } inst_class_e;

    typedef struct packed {
        logic [APB_AW-1:0] paddr;
        logic              psel;
        logic              penable;
        logic              pwrite;
        logic [XLEN-1:0]   pwdata;
    } apb_req_t;

    typedef struct packed {
        logic [XLEN-1:0] prdata;
        logic            pready;
        logic            pslverr;
    } apb_rsp_t;

    // Class is a keyword, hence inst_class
    typedef struct packed {
        opcode_e     opcode;
        inst_class_e inst_class;
        logic [2:0]  funct3;
        logic [6:0]  funct7;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [4:0]  rd;
        logic [11:0] imm12;
        logic [19:0] imm20;
        logic [4:0]  shamt;
        logic        inst_error;
    } decoded_t;

    typedef struct packed {
        logic            valid;
        logic            wr_en;
        logic [4:0]      rd;
        logic [XLEN-1:0] wr_data;
        logic [XLEN-1:0] next_pc;
        logic            illegal;
    } exe_result_t;

endpackage

/* design/friscv_rv32i_decoder.sv */
`timescale 1ns/1ps

module friscv_rv32i_decoder (
    input  logic [friscv_pkg::XLEN-1:0] instruction,
    output friscv_pkg::decoded_t        dec
);

    import friscv_pkg::*;

    opcode_e opc;

    assign opc = opcode_e'(instruction[6:0]);

    always_comb begin
        dec = '0;
        dec.opcode = opc;
        dec.funct3 = instruction[14:12];
        dec.funct7 = instruction[31:25];
        dec.rs1 = instruction[19:15];
        dec.rs2 = instruction[24:20];
        dec.rd = instruction[11:7];
        dec.shamt = instruction[24:20];

        case (opc)
            OPC_AUIPC: begin
                dec.inst_class = CLS_JUMP;
                dec.imm20 = instruction[31:12];
            end

            // J-type, imm[20:1]
            OPC_JAL: begin
                dec.inst_class = CLS_JUMP;
                dec.imm20 = {instruction[31], instruction[19:12],
                             instruction[20], instruction[30:21]};
            end

            OPC_JALR: begin
                dec.inst_class = CLS_JUMP;
                dec.imm12 = instruction[31:20];
            end

            // B-type, imm[12:1]
            OPC_BRANCH: begin
                dec.inst_class = CLS_BRANCH;
                dec.imm12 = {instruction[31], instruction[7],
                             instruction[30:25], instruction[11:8]};
            end

            OPC_FENCE: begin
                dec.inst_class = CLS_SYSTEM;
            end

            OPC_LOAD: begin
                dec.inst_class = CLS_PROCESS;
                dec.imm12 = instruction[31:20];
            end

            OPC_LUI: begin
                dec.inst_class = CLS_PROCESS;
                dec.imm20 = instruction[31:12];
            end

            // S-type
            OPC_STORE: begin
                dec.inst_class = CLS_PROCESS;
                dec.imm12 = {instruction[31:25], instruction[11:7]};
            end

            OPC_OPIMM: begin
                dec.inst_class = CLS_PROCESS;
                dec.imm12 = instruction[31:20];
            end

            OPC_OP: begin
                dec.inst_class = CLS_PROCESS;
            end

            // CSR and environment calls
            OPC_SYSTEM: begin
                dec.inst_class = CLS_PROCESS;
            end

            default: begin
                dec.inst_class = CLS_SYSTEM;
                dec.inst_error = 1'b1;
            end
        endcase
    end

endmodule

/* design/friscv_execute.sv */
`timescale 1ns/1ps

module friscv_execute (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        issue,
    input  friscv_pkg::decoded_t        dec,
    input  logic [friscv_pkg::XLEN-1:0] rs1_data,
    input  logic [friscv_pkg::XLEN-1:0] rs2_data,
    input  logic [friscv_pkg::XLEN-1:0] pc,
    output friscv_pkg::exe_result_t     exe
);

    import friscv_pkg::*;

    logic [XLEN-1:0] imm_i;
    logic [XLEN-1:0] imm_b;
    logic [XLEN-1:0] imm_j;
    logic [XLEN-1:0] imm_u;
    logic [XLEN-1:0] pc_plus4;
    logic            taken;
    logic            valid_q;
    exe_result_t     exe_d;
    exe_result_t     exe_q;

    // Shared by OP and OP-IMM; alt selects SUB or SRA
    function automatic logic [XLEN-1:0] alu_op(input logic [2:0]      f3,
                                               input logic [XLEN-1:0] a,
                                               input logic [XLEN-1:0] b,
                                               input logic            alt,
                                               input logic [4:0]      sh);
        case (f3)
            3'b000: alu_op = alt ? a - b : a + b;
            3'b001: alu_op = a << sh;
            3'b010: alu_op = {{(XLEN-1){1'b0}}, $signed(a) < $signed(b)};
            3'b011: alu_op = {{(XLEN-1){1'b0}}, a < b};
            3'b100: alu_op = a ^ b;
            3'b101: begin
                if (alt) begin
                    alu_op = $signed(a) >>> sh;
                end else begin
                    alu_op = a >> sh;
                end
            end
            3'b110: alu_op = a | b;
            default: alu_op = a & b;
        endcase
    endfunction

    assign imm_i = {{20{dec.imm12[11]}}, dec.imm12};
    assign imm_b = {{19{dec.imm12[11]}}, dec.imm12, 1'b0};
    assign imm_j = {{11{dec.imm20[19]}}, dec.imm20, 1'b0};
    assign imm_u = {dec.imm20, 12'b0};
    assign pc_plus4 = pc + 32'd4;

    always_comb begin
        case (dec.funct3)
            3'b000: taken = rs1_data == rs2_data;
            3'b001: taken = rs1_data != rs2_data;
            3'b100: taken = $signed(rs1_data) < $signed(rs2_data);
            3'b101: taken = $signed(rs1_data) >= $signed(rs2_data);
            3'b110: taken = rs1_data < rs2_data;
            3'b111: taken = rs1_data >= rs2_data;
            default: taken = 1'b0;
        endcase
    end

    always_comb begin
        exe_d = '0;
        exe_d.valid = 1'b1;
        exe_d.rd = dec.rd;
        exe_d.next_pc = pc_plus4;
        case (dec.opcode)
            OPC_LUI: begin
                exe_d.wr_en = 1'b1;
                exe_d.wr_data = imm_u;
            end
            OPC_AUIPC: begin
                exe_d.wr_en = 1'b1;
                exe_d.wr_data = pc + imm_u;
            end
            OPC_JAL: begin
                exe_d.wr_en = 1'b1;
                exe_d.wr_data = pc_plus4;
                exe_d.next_pc = pc + imm_j;
            end
            OPC_JALR: begin
                exe_d.wr_en = 1'b1;
                exe_d.wr_data = pc_plus4;
                exe_d.next_pc = (rs1_data + imm_i) & ~32'd1;
            end
            OPC_BRANCH: begin
                if (taken) begin
                    exe_d.next_pc = pc + imm_b;
                end
            end
            OPC_OPIMM: begin
                exe_d.wr_en = 1'b1;
                exe_d.wr_data = alu_op(dec.funct3, rs1_data, imm_i,
                                       dec.funct3 == 3'b101 && dec.funct7[5], dec.shamt);
            end
            OPC_OP: begin
                exe_d.wr_en = 1'b1;
                exe_d.wr_data = alu_op(dec.funct3, rs1_data, rs2_data,
                                       dec.funct7[5], rs2_data[4:0]);
            end
            // Load, store, fence, system and anything unknown
            default: exe_d.illegal = 1'b1;
        endcase
        if (dec.inst_error) begin
            exe_d.illegal = 1'b1;
            exe_d.wr_en = 1'b0;
            exe_d.next_pc = pc_plus4;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= issue;
        end
    end

    always_ff @(posedge clk) begin
        if (issue) begin
            exe_q <= exe_d;
        end
    end

    always_comb begin
        exe = exe_q;
        exe.valid = valid_q;
    end

endmodule

/* design/friscv_result.sv */
`timescale 1ns/1ps

module friscv_result (
    input  logic                        clk,
    input  logic                        rst,
    input  friscv_pkg::exe_result_t     exe,
    input  logic [4:0]                  rd_addr,
    input  logic [4:0]                  rs1_addr,
    input  logic [4:0]                  rs2_addr,
    output logic [friscv_pkg::XLEN-1:0] rs1_data,
    output logic [friscv_pkg::XLEN-1:0] rs2_data,
    output logic [friscv_pkg::XLEN-1:0] rd_data,
    output logic [friscv_pkg::XLEN-1:0] pc,
    output logic [friscv_pkg::XLEN-1:0] retired,
    output logic [friscv_pkg::XLEN-1:0] illegal
);

    import friscv_pkg::*;

    logic [XLEN-1:0] regs [NREGS];

    // x0 is cleared by reset and never written
    assign rs1_data = regs[rs1_addr];
    assign rs2_data = regs[rs2_addr];
    assign rd_data = regs[rd_addr];

    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= RESET_PC;
            retired <= '0;
            illegal <= '0;
            for (int i = 0; i < NREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (exe.valid) begin
            pc <= exe.next_pc;
            if (exe.illegal) begin
                illegal <= illegal + 32'd1;
            end else begin
                retired <= retired + 32'd1;
            end
            if (exe.wr_en && exe.rd != 5'd0) begin
                regs[exe.rd] <= exe.wr_data;
            end
        end
    end

endmodule

/* design/friscv_apb_slave.sv */
`timescale 1ns/1ps

module friscv_apb_slave (
    input  logic                        clk,
    input  logic                        rst,
    input  friscv_pkg::apb_req_t        apb_req,
    output friscv_pkg::apb_rsp_t        apb_rsp,
    input  logic                        busy,
    output logic [friscv_pkg::XLEN-1:0] instr,
    output logic                        issue,
    output logic [4:0]                  rd_addr,
    input  logic [friscv_pkg::XLEN-1:0] rd_data,
    input  logic [friscv_pkg::XLEN-1:0] pc,
    input  logic [friscv_pkg::XLEN-1:0] retired,
    input  logic [friscv_pkg::XLEN-1:0] illegal
);

    import friscv_pkg::*;

    logic xfer;
    logic reg_area;
    logic wr_instr;
    logic rd_ok;

    // Wait states while an instruction is in flight
    assign xfer = apb_req.psel && apb_req.penable && !busy;

    assign reg_area = apb_req.paddr[7] && apb_req.paddr[1:0] == 2'b00;
    assign rd_addr = apb_req.paddr[6:2];

    assign wr_instr = apb_req.pwrite && apb_req.paddr == ADDR_INSTR;
    assign rd_ok = !apb_req.pwrite && (apb_req.paddr == ADDR_PC ||
                                       apb_req.paddr == ADDR_RETIRED ||
                                       apb_req.paddr == ADDR_ILLEGAL ||
                                       reg_area);

    always_comb begin
        apb_rsp.pready = !busy;
        apb_rsp.pslverr = xfer && !(wr_instr || rd_ok);
        case (apb_req.paddr)
            ADDR_PC: apb_rsp.prdata = pc;
            ADDR_RETIRED: apb_rsp.prdata = retired;
            ADDR_ILLEGAL: apb_rsp.prdata = illegal;
            default: apb_rsp.prdata = reg_area ? rd_data : '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (xfer && wr_instr) begin
            instr <= apb_req.pwdata;
        end
    end

    // One-cycle strobe after the write completes
    always_ff @(posedge clk) begin
        if (rst) begin
            issue <= 1'b0;
        end else begin
            issue <= xfer && wr_instr;
        end
    end

endmodule

/* design/friscv_core_top.sv */
`timescale 1ns/1ps

module friscv_core_top (
    input  logic                 clk,
    input  logic                 rst,
    input  friscv_pkg::apb_req_t apb_req,
    output friscv_pkg::apb_rsp_t apb_rsp
);

    import friscv_pkg::*;

    logic [XLEN-1:0] instr;
    logic            issue;
    logic            busy;
    logic [4:0]      rd_addr;
    logic [XLEN-1:0] rd_data;
    logic [XLEN-1:0] rs1_data;
    logic [XLEN-1:0] rs2_data;
    logic [XLEN-1:0] pc;
    logic [XLEN-1:0] retired;
    logic [XLEN-1:0] illegal;
    decoded_t        dec;
    exe_result_t     exe;

    assign busy = issue | exe.valid;

    friscv_apb_slave i_apb_slave (
        .clk     (clk),
        .rst     (rst),
        .apb_req (apb_req),
        .apb_rsp (apb_rsp),
        .busy    (busy),
        .instr   (instr),
        .issue   (issue),
        .rd_addr (rd_addr),
        .rd_data (rd_data),
        .pc      (pc),
        .retired (retired),
        .illegal (illegal)
    );

    friscv_rv32i_decoder i_decoder (
        .instruction (instr),
        .dec         (dec)
    );

    friscv_execute i_execute (
        .clk      (clk),
        .rst      (rst),
        .issue    (issue),
        .dec      (dec),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .pc       (pc),
        .exe      (exe)
    );

    friscv_result i_result (
        .clk      (clk),
        .rst      (rst),
        .exe      (exe),
        .rd_addr  (rd_addr),
        .rs1_addr (dec.rs1),
        .rs2_addr (dec.rs2),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .rd_data  (rd_data),
        .pc       (pc),
        .retired  (retired),
        .illegal  (illegal)
    );

endmodule

/* testbench/friscv_clk_gen.sv */
`timescale 1ns/1ps

module friscv_clk_gen (
    output logic clk,
    output logic rst
);

    // 10 ns period
    initial begin
        clk = 1'b0;
        forever begin
            #5 clk = ~clk;
        end
    end

    // Held for the first 4 rising edges
    initial begin
        rst <= 1'b1;
        repeat (4) @(posedge clk);
        rst <= 1'b0;
    end

endmodule

/* testbench/friscv_core_assert.sv */
`timescale 1ns/1ps

module friscv_core_assert (
    input logic                        clk,
    input logic                        rst,
    input friscv_pkg::apb_req_t        apb_req,
    input friscv_pkg::apb_rsp_t        apb_rsp,
    input logic                        issue,
    input friscv_pkg::exe_result_t     exe,
    input friscv_pkg::decoded_t        dec,
    input logic [friscv_pkg::XLEN-1:0] rs1_data
);

    int fail_count = 0;

    slverr_on_xfer: assert property (@(posedge clk) disable iff (rst)
        apb_rsp.pslverr |-> apb_req.psel && apb_req.penable && apb_rsp.pready)
    else begin
        fail_count++;
        $error("pslverr outside a completed APB transfer");
    end

    issue_one_cycle: assert property (@(posedge clk) disable iff (rst)
        issue |=> !issue)
    else begin
        fail_count++;
        $error("issue held for more than one cycle");
    end

    // Execute result one cycle behind issue
    valid_after_issue: assert property (@(posedge clk) disable iff (rst)
        exe.valid == $past(issue))
    else begin
        fail_count++;
        $error("exe.valid does not follow issue by one cycle");
    end

    x0_reads_zero: assert property (@(posedge clk) disable iff (rst)
        dec.rs1 == 5'd0 |-> rs1_data == 32'd0)
    else begin
        fail_count++;
        $error("x0 read port returned a nonzero value");
    end

endmodule

/* testbench/friscv_tb.sv */
`timescale 1ns/1ps

module friscv_tb;

    import friscv_pkg::*;

    typedef struct packed {
        logic [31:0] instr;
        logic [4:0]  chk_reg;
        logic [31:0] exp_val;
        logic [31:0] exp_pc;
        logic [31:0] exp_retired;
        logic [31:0] exp_illegal;
    } step_t;

    logic        clk;
    logic        rst;
    apb_req_t    req;
    apb_rsp_t    rsp;
    step_t       steps[$];
    logic [31:0] m_regs [32];
    logic [31:0] m_pc;
    logic [31:0] m_ret;
    logic [31:0] m_ill;

    // Accesses that must end in pslverr
    logic [7:0] bad_addr [6] = '{ADDR_INSTR, ADDR_PC, 8'h40, 8'h10, ADDR_REGBASE, 8'h82};
    logic       bad_wr   [6] = '{1'b0, 1'b1, 1'b0, 1'b1, 1'b1, 1'b0};

    friscv_clk_gen i_clk_gen (
        .clk (clk),
        .rst (rst)
    );

    friscv_core_top i_friscv_core_top (
        .clk     (clk),
        .rst     (rst),
        .apb_req (req),
        .apb_rsp (rsp)
    );

    bind friscv_core_top friscv_core_assert i_core_assert (
        .clk      (clk),
        .rst      (rst),
        .apb_req  (apb_req),
        .apb_rsp  (apb_rsp),
        .issue    (issue),
        .exe      (exe),
        .dec      (dec),
        .rs1_data (rs1_data)
    );

    task automatic check(input string what, input logic [31:0] actual,
                         input logic [31:0] expected);
        if (actual !== expected) begin
            $display("error at %0t ns: %s is %h, expected %h", $time, what, actual, expected);
            $display("Errors found");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic apb_xfer(input logic [7:0] addr, input logic wr, input logic [31:0] wdata,
                            output logic [31:0] rdata, output logic err);
        @(posedge clk);
        req <= '{paddr: addr, psel: 1'b1, penable: 1'b0, pwrite: wr, pwdata: wdata};
        @(posedge clk);
        req.penable <= 1'b1;
        @(negedge clk);
        while (!rsp.pready) begin
            @(negedge clk);
        end
        rdata = rsp.prdata;
        err = rsp.pslverr;
        @(posedge clk);
        req <= '0;
    endtask

    task automatic read_check(input logic [7:0] addr, input logic [31:0] expected,
                              input string what);
        logic [31:0] data;
        logic        err;
        apb_xfer(addr, 1'b0, 32'd0, data, err);
        check({what, " pslverr"}, {31'd0, err}, 32'd0);
        check(what, data, expected);
    endtask

    task automatic check_state(input logic at_reset);
        read_check(ADDR_PC, at_reset ? RESET_PC : m_pc, "pc");
        read_check(ADDR_RETIRED, at_reset ? 32'd0 : m_ret, "retired");
        read_check(ADDR_ILLEGAL, at_reset ? 32'd0 : m_ill, "illegal");
        for (int r = 0; r < NREGS; r++) begin
            read_check(ADDR_REGBASE | 8'(r * 4), at_reset ? 32'd0 : m_regs[r],
                       $sformatf("x%0d", r));
        end
    endtask

    function automatic logic [31:0] op_r(input logic [6:0] f7, input logic [2:0] f3,
                                         input logic [4:0] rd, input logic [4:0] rs1,
                                         input logic [4:0] rs2);
        return {f7, rs2, rs1, f3, rd, OPC_OP};
    endfunction

    function automatic logic [31:0] op_i(input logic [6:0] op, input logic [2:0] f3,
                                         input logic [4:0] rd, input logic [4:0] rs1,
                                         input logic [11:0] imm);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] op_b(input logic [2:0] f3, input logic [4:0] rs1,
                                         input logic [4:0] rs2, input logic [12:0] off);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], OPC_BRANCH};
    endfunction

    function automatic logic [31:0] op_j(input logic [4:0] rd, input logic [20:0] off);
        return {off[20], off[10:1], off[11], off[19:12], rd, OPC_JAL};
    endfunction

    // RV32I integer rules, alt picks SUB or SRA
    function automatic logic [31:0] alu(input logic [2:0] f3, input logic alt,
                                        input logic [31:0] a, input logic [31:0] b);
        logic [31:0] r;
        case (f3)
            3'b000: r = alt ? a - b : a + b;
            3'b001: r = a << b[4:0];
            3'b010: r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'b011: r = (a < b) ? 32'd1 : 32'd0;
            3'b100: r = a ^ b;
            3'b101: begin
                if (alt) begin
                    r = $signed(a) >>> b[4:0];
                end else begin
                    r = a >> b[4:0];
                end
            end
            3'b110: r = a | b;
            default: r = a & b;
        endcase
        return r;
    endfunction

    function automatic void model_exec(input logic [31:0] ins);
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] imm_i;
        logic [31:0] res;
        logic [31:0] nxt;
        logic        wr;
        logic        ill;
        logic        take;
        a = m_regs[ins[19:15]];
        b = m_regs[ins[24:20]];
        imm_i = {{20{ins[31]}}, ins[31:20]};
        res = m_pc + 32'd4;
        nxt = m_pc + 32'd4;
        wr = 1'b1;
        ill = 1'b0;
        take = 1'b0;
        case (ins[6:0])
            OPC_LUI: res = {ins[31:12], 12'd0};
            OPC_AUIPC: res = m_pc + {ins[31:12], 12'd0};
            OPC_JAL: nxt = m_pc + {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
            OPC_JALR: nxt = (a + imm_i) & 32'hffff_fffe;
            OPC_BRANCH: begin
                wr = 1'b0;
                case (ins[14:12])
                    3'b000: take = a == b;
                    3'b001: take = a != b;
                    3'b100: take = $signed(a) < $signed(b);
                    3'b101: take = $signed(a) >= $signed(b);
                    3'b110: take = a < b;
                    default: take = a >= b;
                endcase
                if (take) begin
                    nxt = m_pc + {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
                end
            end
            OPC_OPIMM: res = alu(ins[14:12], ins[14:12] == 3'b101 && ins[30], a, imm_i);
            OPC_OP: res = alu(ins[14:12], ins[30], a, b);
            default: begin
                wr = 1'b0;
                ill = 1'b1;
            end
        endcase
        if (wr && ins[11:7] != 5'd0) begin
            m_regs[ins[11:7]] = res;
        end
        m_pc = nxt;
        if (ill) begin
            m_ill = m_ill + 32'd1;
        end else begin
            m_ret = m_ret + 32'd1;
        end
    endfunction

    function automatic void add_step(input logic [31:0] ins, input logic [4:0] chk);
        step_t s;
        model_exec(ins);
        s.instr = ins;
        s.chk_reg = chk;
        s.exp_val = m_regs[chk];
        s.exp_pc = m_pc;
        s.exp_retired = m_ret;
        s.exp_illegal = m_ill;
        steps.push_back(s);
    endfunction

    function automatic void load_const(input logic [4:0] rd, input logic [31:0] v);
        logic [31:0] up;
        up = v + 32'h800;
        add_step({up[31:12], rd, OPC_LUI}, rd);
        add_step(op_i(OPC_OPIMM, 3'b000, rd, rd, v[11:0]), rd);
    endfunction

    function automatic void build_table();
        logic [31:0] v;
        logic [11:0] imm;
        m_pc = RESET_PC;
        m_ret = '0;
        m_ill = '0;
        foreach (m_regs[r]) begin
            m_regs[r] = '0;
        end
        // Random operands in x1..x4, x4 always negative
        for (int r = 1; r <= 4; r++) begin
            v = $urandom();
            if (r == 4) begin
                v[31] = 1'b1;
            end
            load_const(r[4:0], v);
        end
        for (int f = 0; f < 8; f++) begin
            add_step(op_r(7'h00, f[2:0], 5'(6 + f), 5'd1, 5'd4), 5'(6 + f));
        end
        add_step(op_r(7'h20, 3'b000, 5'd14, 5'd1, 5'd4), 5'd14);
        add_step(op_r(7'h20, 3'b101, 5'd15, 5'd4, 5'd2), 5'd15);
        add_step(op_r(7'h00, 3'b010, 5'd16, 5'd4, 5'd1), 5'd16);
        add_step(op_r(7'h00, 3'b011, 5'd17, 5'd4, 5'd1), 5'd17);
        for (int f = 0; f < 8; f++) begin
            imm = 12'($urandom());
            if (f == 1 || f == 5) begin
                imm = {7'h00, 5'($urandom_range(31, 1))};
            end
            add_step(op_i(OPC_OPIMM, f[2:0], 5'(18 + f), 5'd4, imm), 5'(18 + f));
        end
        add_step(op_i(OPC_OPIMM, 3'b101, 5'd26, 5'd4, {7'h20, 5'($urandom_range(31, 1))}),
                 5'd26);
        // Destination x0 must stay zero
        add_step(op_i(OPC_OPIMM, 3'b000, 5'd0, 5'd1, 12'h123), 5'd0);
        add_step(op_r(7'h00, 3'b000, 5'd0, 5'd1, 5'd2), 5'd0);
        add_step({20'($urandom()), 5'd27, OPC_LUI}, 5'd27);
        add_step({20'($urandom()), 5'd28, OPC_AUIPC}, 5'd28);
        add_step(op_j(5'd29, 21'($urandom_range(2047, 1) * 2)), 5'd29);
        add_step(op_j(5'd30, 21'h1fff00), 5'd30);
        add_step(op_i(OPC_JALR, 3'b000, 5'd31, 5'd1, 12'($urandom())), 5'd31);
        for (int f = 0; f < 8; f++) begin
            if (f != 2 && f != 3) begin
                add_step(op_b(f[2:0], 5'd1, 5'd1, 13'($urandom()) & 13'h1ffe), 5'd1);
                add_step(op_b(f[2:0], 5'd4, 5'd1, 13'($urandom()) & 13'h1ffe), 5'd1);
            end
        end
        // Load, store, fence, ecall, csrrw, custom-0
        add_step(op_i(OPC_LOAD, 3'b010, 5'd5, 5'd1, 12'h010), 5'd5);
        add_step(op_i(OPC_STORE, 3'b010, 5'd5, 5'd1, 12'h002), 5'd5);
        add_step(op_i(OPC_FENCE, 3'b000, 5'd0, 5'd0, 12'h0ff), 5'd1);
        add_step(32'h0000_0073, 5'd1);
        add_step(op_i(OPC_SYSTEM, 3'b001, 5'd5, 5'd1, 12'h300), 5'd5);
        add_step(op_i(7'b0001011, 3'b000, 5'd5, 5'd1, 12'h001), 5'd5);
    endfunction

    initial begin
        int unsigned seed_ret;
        logic [31:0] data;
        logic        err;
        req <= '0;
        seed_ret = $urandom(32'hb920);
        build_table();
        @(negedge rst);
        check_state(1'b1);
        foreach (steps[i]) begin
            apb_xfer(ADDR_INSTR, 1'b1, steps[i].instr, data, err);
            check($sformatf("step %0d write pslverr", i), {31'd0, err}, 32'd0);
            read_check(ADDR_REGBASE | {1'b0, steps[i].chk_reg, 2'b00}, steps[i].exp_val,
                       $sformatf("step %0d x%0d", i, steps[i].chk_reg));
            read_check(ADDR_PC, steps[i].exp_pc, $sformatf("step %0d pc", i));
            read_check(ADDR_RETIRED, steps[i].exp_retired, $sformatf("step %0d retired", i));
            read_check(ADDR_ILLEGAL, steps[i].exp_illegal, $sformatf("step %0d illegal", i));
        end
        foreach (bad_addr[k]) begin
            apb_xfer(bad_addr[k], bad_wr[k], 32'h0000_0013, data, err);
            check($sformatf("pslverr at %h", bad_addr[k]), {31'd0, err}, 32'd1);
        end
        check_state(1'b0);
        $display("No errors");
        $finish;
    end

    // Limit scales with the table built at time 0
    initial begin
        int limit;
        @(posedge clk);
        limit = steps.size() * 20 + 100;
        repeat (limit) @(posedge clk);
        $display("Errors found");
        $fatal(1, "timeout: the test did not finish within %0d clock cycles", limit);
    end

    always @(negedge clk) begin
        if (i_friscv_core_top.i_core_assert.fail_count != 0) begin
            $display("Errors found");
            $fatal(1, "a concurrent assertion on the DUT failed");
        end
    end

endmodule

/* filelist.f */
design/friscv_pkg.sv
design/friscv_rv32i_decoder.sv
design/friscv_execute.sv
design/friscv_result.sv
design/friscv_apb_slave.sv
design/friscv_core_top.sv
testbench/friscv_clk_gen.sv
testbench/friscv_core_assert.sv
testbench/friscv_tb.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module friscv_tb -f filelist.f -o friscv_sim

# Pass or fail is taken from the printed result
out=$(./obj_dir/friscv_sim 2>&1) || true
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -qx "No errors"
